// ==== sources.f ====
+incdir+include
design/tilemap_pkg.sv
design/video_timing.sv
design/tile_layer.sv
design/layer_mixer.sv
design/palette_lookup.sv
design/cpu_port_axil.sv
design/tilemap_video.sv
tests/tilemap_video_tb.sv

// ==== Bender.yml ====
package:
  name: tilemap_video

sources:
  - files:
      - design/tilemap_pkg.sv
      - design/video_timing.sv
      - design/tile_layer.sv
      - design/layer_mixer.sv
      - design/palette_lookup.sv
      - design/cpu_port_axil.sv
      - design/tilemap_video.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tilemap_video_tb.sv

// ==== include/tb_axil_tasks.svh ====
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Cycles before any wait gives up
localparam int WAIT_LIMIT = 20000;

int error_count = 0;

// Compare and count mismatches
task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		error_count++;
		$error("%s: got %h, expected %h", what, got, exp);
	end
endtask

// Drive on the rising edge, look at the falling edge
task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
	output logic [1:0] resp);
	int n = 0;
	@(posedge clk);
	araddr <= addr;
	arvalid <= 1'b1;
	rready <= 1'b1;
	do begin
		@(negedge clk);
		n++;
	end while (!arready && (n < WAIT_LIMIT));
	// Address taken at this edge
	@(posedge clk);
	arvalid <= 1'b0;
	do begin
		@(negedge clk);
		n++;
	end while (!rvalid && (n < WAIT_LIMIT));
	check("read response", n < WAIT_LIMIT, 1'b1);
	data = rdata;
	resp = rresp;
	@(posedge clk);
	rready <= 1'b0;
endtask

// Wait for vertical blanking to reach a level
task automatic wait_vblank(input logic level);
	int n = 0;
	while ((vid_vblank_n !== level) && (n < WAIT_LIMIT)) begin
		@(negedge clk);
		n++;
	end
	check("vblank wait", n < WAIT_LIMIT, 1'b1);
endtask

`endif

// ==== tests/tilemap_video_tb.sv ====
module tilemap_video_tb
	import tilemap_pkg::*;
();

	// Small raster so a frame is quick to capture
	localparam int H_ACTIVE = 64;
	localparam int H_TOTAL = 80;
	localparam int H_SYNC_WIDTH = 4;
	localparam int V_ACTIVE = 16;
	localparam int V_TOTAL = 20;
	localparam int BG_PRIORITY = 2;
	localparam int FG_PRIORITY = 3;

	logic clk;
	logic reset;
	logic [AXI_ADDR_WIDTH-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXI_DATA_WIDTH-1:0] wdata;
	logic [AXI_DATA_WIDTH/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_WIDTH-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXI_DATA_WIDTH-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [COMPONENT_DEPTH-1:0] vid_red;
	logic [COMPONENT_DEPTH-1:0] vid_green;
	logic [COMPONENT_DEPTH-1:0] vid_blue;
	logic vid_hsync_n;
	logic vid_vsync_n;
	logic vid_hblank_n;
	logic vid_vblank_n;

	// Reference copies of everything the CPU has loaded
	logic [31:0] map_model [2][MAP_WORDS];
	logic [31:0] pat_model [2][PATTERN_WORDS];
	logic [11:0] pal_model [PALETTE_WORDS];
	scroll_t scroll_model [2];
	logic [1:0] mask_model;

	`include "tb_axil_tasks.svh"

	tilemap_video #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.H_SYNC_WIDTH(H_SYNC_WIDTH),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.BACKGROUND_LAYER_PRIORITY(BG_PRIORITY),
		.FOREGROUND_LAYER_PRIORITY(FG_PRIORITY)
	) tilemap_video_inst (.*);

	always #5 clk = ~clk;

	////////////////////////////////////////
	// Error handling
	////////////////////////////////////////

	task automatic halt_on_error();
		if (error_count != 0) begin
			$display("Verification failed");
			$fatal(1, "stopping after the first error");
		end
	endtask

	task automatic expect_eq(input string test, input string what, input logic [31:0] got,
		input logic [31:0] exp);
		check($sformatf("mismatch in %s, %s", test, what), got, exp);
		halt_on_error();
	endtask

	// Plain condition, used for timeouts
	task automatic require(input string what, input logic ok);
		check(what, ok, 1'b1);
		halt_on_error();
	endtask

	////////////////////////////////////////
	// Bus access
	////////////////////////////////////////

	// Returns on the rising edge that takes the write
	task automatic await_write_accept();
		int n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!(awready && wready) && (n < WAIT_LIMIT));
		require("write address and data were never accepted", awready && wready);
		@(posedge clk);
	endtask

	task automatic await_write_response(output logic [1:0] resp);
		int n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!bvalid && (n < WAIT_LIMIT));
		require("write response never arrived", bvalid);
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		wstrb <= 4'hf;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		bready <= 1'b1;
		await_write_accept();
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		await_write_response(resp);
	endtask

	task automatic fetch_reg(input logic [15:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		axil_read(addr, data, resp);
		halt_on_error();
	endtask

	task automatic await_vblank(input logic level);
		wait_vblank(level);
		halt_on_error();
	endtask

	////////////////////////////////////////
	// Loading and model state
	////////////////////////////////////////

	// Half of the nibbles transparent
	function automatic logic [31:0] sparse_row();
		logic [31:0] row;
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r = $urandom;
			row[i*4 +: 4] = r[0] ? 4'h0 : r[4:1];
		end
		return row;
	endfunction

	task automatic load_map(input int layer);
		logic [31:0] data;
		logic [1:0] resp;
		for (int i = 0; i < MAP_WORDS; i++) begin
			// Full random word, unused bits included
			data = $urandom;
			map_model[layer][i] = data;
			write_word(16'((layer ? MAP1_BASE : MAP0_BASE) + i * 4), data, resp);
			expect_eq("load_map", "bresp", resp, RESP_OKAY);
		end
	endtask

	task automatic load_patterns(input int layer, input logic sparse);
		logic [31:0] data;
		logic [1:0] resp;
		for (int i = 0; i < PATTERN_WORDS; i++) begin
			data = sparse ? sparse_row() : $urandom;
			pat_model[layer][i] = data;
			write_word(16'((layer ? PAT1_BASE : PAT0_BASE) + i * 4), data, resp);
			expect_eq("load_patterns", "bresp", resp, RESP_OKAY);
		end
	endtask

	task automatic load_palette();
		logic [31:0] data;
		logic [1:0] resp;
		for (int i = 0; i < PALETTE_WORDS; i++) begin
			data = $urandom;
			pal_model[i] = data[11:0];
			write_word(16'(PALETTE_BASE + i * 4), data, resp);
			expect_eq("load_palette", "bresp", resp, RESP_OKAY);
		end
	endtask

	task automatic set_scroll(input int layer, input logic [7:0] x, input logic [7:0] y);
		logic [1:0] resp;
		scroll_model[layer].x = x;
		scroll_model[layer].y = y;
		write_word(CTRL_BASE + (layer ? CTRL_FG_SCROLL : CTRL_BG_SCROLL), {16'h0, y, x}, resp);
		expect_eq("set_scroll", "bresp", resp, RESP_OKAY);
	endtask

	task automatic set_mask(input logic [1:0] mask);
		logic [1:0] resp;
		mask_model = mask;
		write_word(CTRL_BASE + CTRL_LAYER_MASK, {30'h0, mask}, resp);
		expect_eq("set_mask", "bresp", resp, RESP_OKAY);
	endtask

	////////////////////////////////////////
	// Reference pixel
	////////////////////////////////////////

	function automatic logic [11:0] model_rgb(input int x, input int y);
		logic [7:0] sx;
		logic [7:0] sy;
		logic [31:0] entry;
		logic [31:0] row;
		logic [3:0] code [2];
		logic [3:0] bank [2];
		logic [7:0] index;
		for (int l = 0; l < 2; l++) begin
			code[l] = 4'h0;
			bank[l] = 4'h0;
			// Masked layers count as transparent
			if (!mask_model[l]) begin
				sx = x + scroll_model[l].x;
				sy = y + scroll_model[l].y;
				// 32 tiles per map row
				entry = map_model[l][(sy / 8) * 32 + sx / 8];
				row = pat_model[l][entry[5:0] * 8 + sy % 8];
				code[l] = row[(sx % 8) * 4 +: 4];
				bank[l] = entry[11:8];
			end
		end
		if ((code[1] != 0) && ((code[0] == 0) || (FG_PRIORITY > BG_PRIORITY)))
			index = {bank[1], code[1]};
		else if (code[0] != 0)
			index = {bank[0], code[0]};
		else
			index = 8'h00;
		return pal_model[index];
	endfunction

	// Two frame starts pass first, so new scrolls cover the whole frame
	task automatic compare_frame(input string test);
		int idx = 0;
		int n = 0;
		int blank_run = 0;
		int low = 0;
		int x;
		int y;
		logic [11:0] rgb;
		await_vblank(1'b1);
		await_vblank(1'b0);
		await_vblank(1'b1);
		await_vblank(1'b0);
		await_vblank(1'b1);
		while ((idx < H_ACTIVE * V_ACTIVE) && (n < WAIT_LIMIT)) begin
			rgb = {vid_red, vid_green, vid_blue};
			x = idx % H_ACTIVE;
			y = idx / H_ACTIVE;
			expect_eq(test, "vsync_n in active lines", vid_vsync_n, 1'b1);
			if (vid_hblank_n) begin
				expect_eq(test, $sformatf("pixel x=%0d y=%0d", x, y), rgb, model_rgb(x, y));
				expect_eq(test, "hsync_n in active part", vid_hsync_n, 1'b1);
				blank_run = 0;
				idx++;
			end else begin
				expect_eq(test, "blanked pixel", rgb, 12'h000);
				// Sync pulse opens the horizontal blank
				expect_eq(test, "hsync_n in blank", vid_hsync_n, blank_run >= H_SYNC_WIDTH);
				blank_run++;
			end
			@(negedge clk);
			n++;
		end
		require("frame capture timed out", idx == H_ACTIVE * V_ACTIVE);
		// Vertical sync lasts one whole line
		n = 0;
		while (vid_vsync_n && (n < WAIT_LIMIT)) begin
			@(negedge clk);
			n++;
		end
		require("vertical sync never started", !vid_vsync_n);
		while (!vid_vsync_n && (n < WAIT_LIMIT)) begin
			expect_eq(test, "vblank_n during vsync", vid_vblank_n, 1'b0);
			@(negedge clk);
			n++;
			low++;
		end
		require("vertical sync never ended", vid_vsync_n);
		expect_eq(test, "vsync length", low, H_TOTAL);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic after_reset();
		logic [31:0] data;
		logic [1:0] resp;
		expect_eq("after_reset", "rgb", {vid_red, vid_green, vid_blue}, 12'h000);
		expect_eq("after_reset", "hsync_n", vid_hsync_n, 1'b1);
		expect_eq("after_reset", "vsync_n", vid_vsync_n, 1'b1);
		expect_eq("after_reset", "hblank_n", vid_hblank_n, 1'b0);
		expect_eq("after_reset", "vblank_n", vid_vblank_n, 1'b0);
		expect_eq("after_reset", "bvalid", bvalid, 1'b0);
		expect_eq("after_reset", "rvalid", rvalid, 1'b0);
		for (int off = 0; off <= 8; off += 4) begin
			fetch_reg(16'(CTRL_BASE + off), data, resp);
			expect_eq("after_reset", $sformatf("control 0x%0h", off), data, 32'h0);
			expect_eq("after_reset", "rresp", resp, RESP_OKAY);
		end
	endtask

	task automatic register_access();
		logic [31:0] data;
		logic [1:0] resp;
		set_scroll(0, 8'h5a, 8'ha5);
		set_scroll(1, 8'h96, 8'h3c);
		set_mask(2'b10);
		fetch_reg(CTRL_BASE + CTRL_BG_SCROLL, data, resp);
		expect_eq("register_access", "bg scroll", data, 32'h0000_a55a);
		fetch_reg(CTRL_BASE + CTRL_FG_SCROLL, data, resp);
		expect_eq("register_access", "fg scroll", data, 32'h0000_3c96);
		fetch_reg(CTRL_BASE + CTRL_LAYER_MASK, data, resp);
		expect_eq("register_access", "mask", data, 32'h2);
		// Memories are write only
		fetch_reg(MAP0_BASE, data, resp);
		expect_eq("register_access", "map read rresp", resp, RESP_SLVERR);
		expect_eq("register_access", "map read data", data, 32'h0);
		write_word(16'h6000, 32'hdead_beef, resp);
		expect_eq("register_access", "unmapped write bresp", resp, RESP_SLVERR);
		set_scroll(0, 8'h00, 8'h00);
		set_scroll(1, 8'h00, 8'h00);
		set_mask(2'b00);
	endtask

	task automatic write_backpressure();
		logic [31:0] data;
		logic [1:0] resp;
		@(posedge clk);
		awaddr <= CTRL_BASE + CTRL_BG_SCROLL;
		wdata <= 32'h0000_1234;
		wstrb <= 4'hf;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		bready <= 1'b0;
		await_write_accept();
		// Second write offered while the first response is held
		awaddr <= CTRL_BASE + CTRL_FG_SCROLL;
		wdata <= 32'h0000_5678;
		repeat (8) begin
			@(negedge clk);
			expect_eq("write_backpressure", "bvalid held", bvalid, 1'b1);
			expect_eq("write_backpressure", "awready while blocked", awready, 1'b0);
		end
		expect_eq("write_backpressure", "first bresp", bresp, RESP_OKAY);
		@(posedge clk);
		bready <= 1'b1;
		await_write_accept();
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		await_write_response(resp);
		expect_eq("write_backpressure", "second bresp", resp, RESP_OKAY);
		fetch_reg(CTRL_BASE + CTRL_BG_SCROLL, data, resp);
		expect_eq("write_backpressure", "first readback", data, 32'h0000_1234);
		fetch_reg(CTRL_BASE + CTRL_FG_SCROLL, data, resp);
		expect_eq("write_backpressure", "second readback", data, 32'h0000_5678);
	endtask

	initial begin
		void'($urandom(32'hf56));
		clk = 1'b0;
		reset <= 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		mask_model = 2'b00;
		scroll_model[0] = '0;
		scroll_model[1] = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		after_reset();
		register_access();

		// Background alone
		load_patterns(0, 1'b0);
		load_map(0);
		load_palette();
		set_mask(2'b10);
		compare_frame("single_layer_render");

		// Foreground with plenty of holes
		load_patterns(1, 1'b1);
		load_map(1);
		set_mask(2'b00);
		compare_frame("both_layers");
		set_mask(2'b10);
		compare_frame("foreground_masked");
		set_mask(2'b11);
		compare_frame("both_masked");

		// Offsets chosen to wrap past 256 in x and y
		set_mask(2'b00);
		set_scroll(0, 8'he5, 8'hf8);
		set_scroll(1, 8'h3c, 8'hfc);
		compare_frame("scroll_wrap");

		write_backpressure();

		if (error_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			halt_on_error();
		end
	end

endmodule

// ==== design/tilemap_video.sv ====
module tilemap_video
	import tilemap_pkg::*;
#(
	parameter int H_ACTIVE = 288,
	parameter int H_TOTAL = 384,
	parameter int H_SYNC_WIDTH = 32,
	parameter int V_ACTIVE = 224,
	parameter int V_TOTAL = 264,
	parameter int BACKGROUND_LAYER_PRIORITY = 2,
	parameter int FOREGROUND_LAYER_PRIORITY = 3
) (
	input logic clk,
	input logic reset,
	input logic [AXI_ADDR_WIDTH-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [AXI_DATA_WIDTH-1:0] wdata,
	input logic [AXI_DATA_WIDTH/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [AXI_ADDR_WIDTH-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [AXI_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic [COMPONENT_DEPTH-1:0] vid_red,
	output logic [COMPONENT_DEPTH-1:0] vid_green,
	output logic [COMPONENT_DEPTH-1:0] vid_blue,
	output logic vid_hsync_n,
	output logic vid_vsync_n,
	output logic vid_hblank_n,
	output logic vid_vblank_n
);

	beam_t beam;
	logic frame_start;
	mem_wr_t mem_wr;
	scroll_t bg_scroll;
	scroll_t fg_scroll;
	logic [1:0] disable_mask;

	// Layer outputs, three cycles behind the counters
	layer_px_t bg_pixel;
	layer_px_t fg_pixel;
	beam_t bg_beam;
	beam_t fg_beam;

	// Mixer output, four cycles behind
	logic [7:0] color_index;
	beam_t mix_beam;

	////////////////////////////////////////
	// Raster and layers
	////////////////////////////////////////

	video_timing #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.H_SYNC_WIDTH(H_SYNC_WIDTH),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL)
	) video_timing_inst (
		.clk,
		.reset,
		.beam,
		.frame_start
	);

	// Layer 0 is the background
	tile_layer #(.LAYER_ID(0)) bg_layer_inst (
		.clk,
		.reset,
		.beam,
		.scroll(bg_scroll),
		.mem_wr,
		.pixel(bg_pixel),
		.beam_out(bg_beam)
	);

	tile_layer #(.LAYER_ID(1)) fg_layer_inst (
		.clk,
		.reset,
		.beam,
		.scroll(fg_scroll),
		.mem_wr,
		.pixel(fg_pixel),
		.beam_out(fg_beam)
	);

	////////////////////////////////////////
	// Mixing, colour and bus
	////////////////////////////////////////

	layer_mixer #(
		.BACKGROUND_LAYER_PRIORITY(BACKGROUND_LAYER_PRIORITY),
		.FOREGROUND_LAYER_PRIORITY(FOREGROUND_LAYER_PRIORITY)
	) layer_mixer_inst (
		.clk,
		.reset,
		.bg_pixel,
		.fg_pixel,
		.beam(bg_beam),
		.disable_mask,
		.color_index,
		.beam_out(mix_beam)
	);

	palette_lookup #(.V_ACTIVE(V_ACTIVE)) palette_lookup_inst (
		.*,
		.beam(mix_beam)
	);

	cpu_port_axil cpu_port_axil_inst (.*);

endmodule

// ==== design/cpu_port_axil.sv ====
module cpu_port_axil
	import tilemap_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [AXI_ADDR_WIDTH-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [AXI_DATA_WIDTH-1:0] wdata,
	input logic [AXI_DATA_WIDTH/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [AXI_ADDR_WIDTH-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [AXI_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic frame_start,
	output mem_wr_t mem_wr,
	output scroll_t bg_scroll,
	output scroll_t fg_scroll,
	output logic [1:0] disable_mask
);

	typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
	typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;

	wr_state_e wr_state;
	rd_state_e rd_state;

	logic wr_fire;
	logic [9:0] aw_word;
	mem_target_e aw_target;
	logic aw_mem;
	logic aw_ctrl;
	logic ar_ok;
	logic [AXI_DATA_WIDTH-1:0] ctrl_rdata;

	// Values as written, copied to the layers once per frame
	scroll_t bg_scroll_reg;
	scroll_t fg_scroll_reg;

	function automatic logic ctrl_offset_ok(input logic [11:0] offset);
		return (offset == CTRL_BG_SCROLL) || (offset == CTRL_FG_SCROLL) ||
			(offset == CTRL_LAYER_MASK);
	endfunction

	////////////////////////////////////////
	// Write address decode
	////////////////////////////////////////

	assign aw_word = awaddr[11:2];

	always_comb begin
		aw_target = TGT_MAP0;
		aw_mem = 1'b0;
		aw_ctrl = 1'b0;
		case (awaddr[15:12])
			MAP0_BASE[15:12]: begin
				aw_target = TGT_MAP0;
				aw_mem = (aw_word < MAP_WORDS);
			end
			MAP1_BASE[15:12]: begin
				aw_target = TGT_MAP1;
				aw_mem = (aw_word < MAP_WORDS);
			end
			PAT0_BASE[15:12]: begin
				aw_target = TGT_PAT0;
				aw_mem = (aw_word < PATTERN_WORDS);
			end
			PAT1_BASE[15:12]: begin
				aw_target = TGT_PAT1;
				aw_mem = (aw_word < PATTERN_WORDS);
			end
			PALETTE_BASE[15:12]: begin
				aw_target = TGT_PALETTE;
				aw_mem = (aw_word < PALETTE_WORDS);
			end
			CTRL_BASE[15:12]: aw_ctrl = ctrl_offset_ok(awaddr[11:0]);
			default: ;
		endcase
	end

	////////////////////////////////////////
	// Write channel
	////////////////////////////////////////

	// Address and data taken together, only with no response pending
	assign awready = (wr_state == WR_IDLE) && awvalid && wvalid;
	assign wready = awready;
	assign wr_fire = awready;
	assign bvalid = (wr_state == WR_RESP);

	always_ff @(posedge clk) begin
		// Broadcast payload, qualified by valid
		mem_wr.target <= aw_target;
		mem_wr.addr <= aw_word;
		mem_wr.data <= wdata;
		if (wr_fire)
			bresp <= (aw_mem || aw_ctrl) ? RESP_OKAY : RESP_SLVERR;

		if (reset) begin
			wr_state <= WR_IDLE;
			mem_wr.valid <= 1'b0;
			bg_scroll_reg <= '0;
			fg_scroll_reg <= '0;
			disable_mask <= '0;
		end else begin
			// Memories take whole words regardless of strobes
			mem_wr.valid <= wr_fire && aw_mem;
			case (wr_state)
				WR_IDLE: if (wr_fire) wr_state <= WR_RESP;
				WR_RESP: if (bready) wr_state <= WR_IDLE;
			endcase
			if (wr_fire && aw_ctrl) begin
				case (awaddr[11:0])
					CTRL_BG_SCROLL: begin
						if (wstrb[0]) bg_scroll_reg.x <= wdata[7:0];
						if (wstrb[1]) bg_scroll_reg.y <= wdata[15:8];
					end
					CTRL_FG_SCROLL: begin
						if (wstrb[0]) fg_scroll_reg.x <= wdata[7:0];
						if (wstrb[1]) fg_scroll_reg.y <= wdata[15:8];
					end
					default: if (wstrb[0]) disable_mask <= wdata[1:0];
				endcase
			end
		end
	end

	// Active scroll set changes only between frames
	always_ff @(posedge clk) begin
		if (reset) begin
			bg_scroll <= '0;
			fg_scroll <= '0;
		end else if (frame_start) begin
			bg_scroll <= bg_scroll_reg;
			fg_scroll <= fg_scroll_reg;
		end
	end

	////////////////////////////////////////
	// Read channel
	////////////////////////////////////////

	// Only the control registers read back
	assign ar_ok = (araddr[15:12] == CTRL_BASE[15:12]) && ctrl_offset_ok(araddr[11:0]);

	always_comb begin
		case (araddr[11:0])
			CTRL_BG_SCROLL: ctrl_rdata = {16'h0, bg_scroll_reg.y, bg_scroll_reg.x};
			CTRL_FG_SCROLL: ctrl_rdata = {16'h0, fg_scroll_reg.y, fg_scroll_reg.x};
			default: ctrl_rdata = {30'h0, disable_mask};
		endcase
	end

	assign arready = (rd_state == RD_IDLE);
	assign rvalid = (rd_state == RD_RESP);

	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			rdata <= ar_ok ? ctrl_rdata : '0;
			rresp <= ar_ok ? RESP_OKAY : RESP_SLVERR;
		end
		if (reset)
			rd_state <= RD_IDLE;
		else begin
			case (rd_state)
				RD_IDLE: if (arvalid) rd_state <= RD_RESP;
				RD_RESP: if (rready) rd_state <= RD_IDLE;
			endcase
		end
	end

	// Responses stay put until the master takes them
	assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));
	assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== design/palette_lookup.sv ====
module palette_lookup
	import tilemap_pkg::*;
#(
	parameter int V_ACTIVE = 224
) (
	input logic clk,
	input logic reset,
	input logic [7:0] color_index,
	input beam_t beam,
	input mem_wr_t mem_wr,
	output logic [COMPONENT_DEPTH-1:0] vid_red,
	output logic [COMPONENT_DEPTH-1:0] vid_green,
	output logic [COMPONENT_DEPTH-1:0] vid_blue,
	output logic vid_hsync_n,
	output logic vid_vsync_n,
	output logic vid_hblank_n,
	output logic vid_vblank_n
);

	// Red, green, blue from high to low nibble
	logic [3*COMPONENT_DEPTH-1:0] palette_ram [PALETTE_WORDS];
	logic [3*COMPONENT_DEPTH-1:0] entry;

	always_ff @(posedge clk) begin
		if (mem_wr.valid && (mem_wr.target == TGT_PALETTE))
			palette_ram[mem_wr.addr[7:0]] <= mem_wr.data[3*COMPONENT_DEPTH-1:0];
	end

	assign entry = palette_ram[color_index];

	////////////////////////////////////////
	// Video output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			vid_red <= '0;
			vid_green <= '0;
			vid_blue <= '0;
			vid_hsync_n <= 1'b1;
			vid_vsync_n <= 1'b1;
			vid_hblank_n <= 1'b0;
			vid_vblank_n <= 1'b0;
		end else begin
			// Black outside the visible window
			vid_red <= beam.active ? entry[3*COMPONENT_DEPTH-1 -: COMPONENT_DEPTH] : '0;
			vid_green <= beam.active ? entry[2*COMPONENT_DEPTH-1 -: COMPONENT_DEPTH] : '0;
			vid_blue <= beam.active ? entry[COMPONENT_DEPTH-1:0] : '0;
			vid_hsync_n <= beam.hsync_n;
			vid_vsync_n <= beam.vsync_n;
			vid_hblank_n <= beam.active;
			vid_vblank_n <= (beam.y < V_ACTIVE);
		end
	end

endmodule

// ==== design/layer_mixer.sv ====
module layer_mixer
	import tilemap_pkg::*;
#(
	parameter int BACKGROUND_LAYER_PRIORITY = 2,
	parameter int FOREGROUND_LAYER_PRIORITY = 3
) (
	input logic clk,
	input logic reset,
	input layer_px_t bg_pixel,
	input layer_px_t fg_pixel,
	input beam_t beam,
	input logic [1:0] disable_mask,
	output logic [7:0] color_index,
	output beam_t beam_out
);

	logic bg_candidate;
	logic fg_candidate;
	logic fg_wins;

	////////////////////////////////////////
	// Layer selection
	////////////////////////////////////////

	// Opaque and not masked off
	assign bg_candidate = (bg_pixel.code != 4'd0) && !disable_mask[0];
	assign fg_candidate = (fg_pixel.code != 4'd0) && !disable_mask[1];

	// Alone, or outranking the background
	assign fg_wins = fg_candidate &&
		(!bg_candidate || (FOREGROUND_LAYER_PRIORITY > BACKGROUND_LAYER_PRIORITY));

	always_ff @(posedge clk) begin
		if (reset) begin
			color_index <= '0;
			beam_out <= BEAM_IDLE;
		end else begin
			beam_out <= beam;
			if (fg_wins)
				color_index <= {fg_pixel.bank, fg_pixel.code};
			else if (bg_candidate)
				color_index <= {bg_pixel.bank, bg_pixel.code};
			else
				// Nothing opaque, backdrop colour
				color_index <= '0;
		end
	end

	// Equal priorities would make the order undefined
	assert property (@(posedge clk)
		BACKGROUND_LAYER_PRIORITY != FOREGROUND_LAYER_PRIORITY);

endmodule

// ==== design/tile_layer.sv ====
module tile_layer
	import tilemap_pkg::*;
#(
	parameter int LAYER_ID = 0
) (
	input logic clk,
	input logic reset,
	input beam_t beam,
	input scroll_t scroll,
	input mem_wr_t mem_wr,
	output layer_px_t pixel,
	output beam_t beam_out
);

	// Write targets this layer answers to
	localparam mem_target_e MAP_TARGET = mem_target_e'(LAYER_ID == 0 ? TGT_MAP0 : TGT_MAP1);
	localparam mem_target_e PAT_TARGET = mem_target_e'(LAYER_ID == 0 ? TGT_PAT0 : TGT_PAT1);

	// Map entry kept as bank and tile index
	logic [9:0] map_ram [MAP_WORDS];
	logic [31:0] pattern_ram [PATTERN_WORDS];

	logic [7:0] scrolled_x;
	logic [7:0] scrolled_y;

	// Stage 1 holds the map entry
	logic [9:0] s1_entry;
	logic [2:0] s1_fine_x;
	logic [2:0] s1_fine_y;
	beam_t s1_beam;

	// Stage 2 holds the pattern row
	logic [31:0] s2_row;
	logic [3:0] s2_bank;
	logic [2:0] s2_fine_x;
	beam_t s2_beam;

	////////////////////////////////////////
	// CPU loads
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (mem_wr.valid && (mem_wr.target == MAP_TARGET))
			map_ram[mem_wr.addr] <= {mem_wr.data[11:8], mem_wr.data[5:0]};
		if (mem_wr.valid && (mem_wr.target == PAT_TARGET))
			pattern_ram[mem_wr.addr[8:0]] <= mem_wr.data;
	end

	////////////////////////////////////////
	// Fetch pipeline
	////////////////////////////////////////

	// Scrolled position wraps at 256
	assign scrolled_x = beam.x[7:0] + scroll.x;
	assign scrolled_y = beam.y[7:0] + scroll.y;

	always_ff @(posedge clk) begin
		// Map read, row y/8 and column x/8
		s1_entry <= map_ram[{scrolled_y[7:3], scrolled_x[7:3]}];
		s1_fine_x <= scrolled_x[2:0];
		s1_fine_y <= scrolled_y[2:0];

		// Pattern read, tile index then row in tile
		s2_row <= pattern_ram[{s1_entry[5:0], s1_fine_y}];
		s2_bank <= s1_entry[9:6];
		s2_fine_x <= s1_fine_x;

		// Nibble select, leftmost pixel in the low nibble
		pixel.code <= s2_row[{s2_fine_x, 2'b00} +: 4];
		pixel.bank <= s2_bank;
	end

	// Beam follows its pixel through all three stages
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_beam <= BEAM_IDLE;
			s2_beam <= BEAM_IDLE;
			beam_out <= BEAM_IDLE;
		end else begin
			s1_beam <= beam;
			s2_beam <= s1_beam;
			beam_out <= s2_beam;
		end
	end

endmodule

// ==== design/video_timing.sv ====
module video_timing
	import tilemap_pkg::*;
#(
	parameter int H_ACTIVE = 288,
	parameter int H_TOTAL = 384,
	parameter int H_SYNC_WIDTH = 32,
	parameter int V_ACTIVE = 224,
	parameter int V_TOTAL = 264
) (
	input logic clk,
	input logic reset,
	output beam_t beam,
	output logic frame_start
);

	logic [8:0] x_count;
	logic [8:0] y_count;

	////////////////////////////////////////
	// Beam counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			x_count <= '0;
			y_count <= '0;
		end else if (x_count == H_TOTAL - 1) begin
			x_count <= '0;
			// Wrap to the top after the last line
			if (y_count == V_TOTAL - 1)
				y_count <= '0;
			else
				y_count <= y_count + 9'd1;
		end else begin
			x_count <= x_count + 9'd1;
		end
	end

	////////////////////////////////////////
	// Sync and active window
	////////////////////////////////////////

	always_comb begin
		beam.x = x_count;
		beam.y = y_count;
		// Sync right after the visible part of the line
		beam.hsync_n = !((x_count >= H_ACTIVE) && (x_count < H_ACTIVE + H_SYNC_WIDTH));
		// One sync line after the last visible line
		beam.vsync_n = (y_count != V_ACTIVE);
		beam.active = (x_count < H_ACTIVE) && (y_count < V_ACTIVE);
	end

	// First slot of the frame
	assign frame_start = (x_count == '0) && (y_count == '0);

	// Counters never pass their totals
	assert property (@(posedge clk) disable iff (reset)
		(x_count < H_TOTAL) && (y_count < V_TOTAL));

endmodule

// ==== design/tilemap_pkg.sv ====
package tilemap_pkg;

	////////////////////////////////////////
	// Fixed sizes
	////////////////////////////////////////

	// Bits per colour component
	localparam int COMPONENT_DEPTH = 4;

	// 32 x 32 tiles per layer
	localparam int MAP_WORDS = 1024;
	// 64 tiles, 8 rows of 8 nibbles each
	localparam int PATTERN_WORDS = 512;
	// 12-bit colours, red in the top nibble
	localparam int PALETTE_WORDS = 256;

	// CPU bus
	localparam int AXI_ADDR_WIDTH = 16;
	localparam int AXI_DATA_WIDTH = 32;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	////////////////////////////////////////
	// Address map
	////////////////////////////////////////

	// Byte address of each region
	localparam logic [15:0] MAP0_BASE = 16'h0000;
	localparam logic [15:0] MAP1_BASE = 16'h1000;
	localparam logic [15:0] PAT0_BASE = 16'h2000;
	localparam logic [15:0] PAT1_BASE = 16'h3000;
	localparam logic [15:0] PALETTE_BASE = 16'h4000;
	localparam logic [15:0] CTRL_BASE = 16'h5000;

	// Control offsets, scroll x in 7..0 and y in 15..8
	localparam logic [11:0] CTRL_BG_SCROLL = 12'h000;
	localparam logic [11:0] CTRL_FG_SCROLL = 12'h004;
	localparam logic [11:0] CTRL_LAYER_MASK = 12'h008;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// Memory that a CPU write lands in
	typedef enum logic [2:0] {
		TGT_MAP0,
		TGT_MAP1,
		TGT_PAT0,
		TGT_PAT1,
		TGT_PALETTE
	} mem_target_e;

	// Single-cycle write broadcast
	typedef struct packed {
		logic valid;
		mem_target_e target;
		logic [9:0] addr;
		logic [31:0] data;
	} mem_wr_t;

	// One pixel slot of the raster
	typedef struct packed {
		logic [8:0] x;
		logic [8:0] y;
		logic hsync_n;
		logic vsync_n;
		logic active;
	} beam_t;

	// Code 0 is transparent
	typedef struct packed {
		logic [3:0] bank;
		logic [3:0] code;
	} layer_px_t;

	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
	} scroll_t;

	// Idle slot for pipeline reset, outside every active range
	localparam beam_t BEAM_IDLE = '{x: '1, y: '1, hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0};

endpackage
